// File: sim.f
snes_cart_pkg.sv
header_detect.sv
ram_clear.sv
backup_sync.sv
mem_arbiter.sv
save_ram.sv
cart_top.sv
tb_cart_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_top -f sim.f \
	&& ./obj_dir/Vtb_cart_top | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "Run passed" \
	|| { echo "Run failed"; exit 1; }

// File: tb_cart_top.sv
// Self-checking testbench for cart_top with random downloads, an SD host model and system port checks
`default_nettype none
`timescale 1ns/1ps

module tb_cart_top
	import snes_cart_pkg::*;
();

	localparam int ADDR_BITS    = 12;
	localparam int DEPTH        = 1 << ADDR_BITS;
	localparam int CLEAR_CYCLES = 2 * DEPTH;

	logic                   clk_sys = 1'b0;
	logic                   RESET;
	logic                   dl_active, dl_wr;
	logic [DL_ADDR_W-1:0]   dl_addr;
	logic [DL_DATA_W-1:0]   dl_data;
	rom_map_e               map_sel;
	region_sel_e            region_sel;
	fill_pat_e              fill_sel;
	logic                   img_mounted, img_readonly, bk_load_req, bk_save_req;
	logic [LBA_W-1:0]       sd_lba;
	logic                   sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [SECTOR_BITS-1:0] sd_buff_addr;
	logic [7:0]             sd_buff_dout, sd_buff_din;
	logic [MASK_W-1:0]      sys_addr;
	logic [7:0]             sys_wdata, sys_rdata;
	logic                   sys_rd, sys_wr;
	logic [MASK_W-1:0]      rom_mask, ram_mask;
	logic [7:0]             rom_type;
	logic                   pal, sys_busy, bk_busy;

	// Reference model state
	logic [7:0]             model_mem [0:DEPTH-1];
	logic [MASK_W-1:0]      ram_mask_m;
	logic                   bk_ena_m;

	cart_top #(.SAVE_ADDR_BITS(ADDR_BITS)) dut (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active(dl_active), .dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr),
		.map_sel(map_sel), .region_sel(region_sel), .fill_sel(fill_sel),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.bk_load_req(bk_load_req), .bk_save_req(bk_save_req),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_buff_din(sd_buff_din),
		.sys_addr(sys_addr), .sys_wdata(sys_wdata), .sys_rd(sys_rd), .sys_wr(sys_wr),
		.sys_rdata(sys_rdata), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.rom_type(rom_type), .pal(pal), .sys_busy(sys_busy), .bk_busy(bk_busy)
	);

	always #4 clk_sys = ~clk_sys;

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else
			fail_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	function automatic logic [7:0] fill_byte(input fill_pat_e pat, input logic [ADDR_BITS-1:0] a);
		case (pat)
			pat_alt_9966: fill_byte = (a[8] != a[2]) ? 8'h66 : 8'h99;
			pat_alt_00ff: fill_byte = (a[9] != a[0]) ? 8'hFF : 8'h00;
			pat_const_55: fill_byte = 8'h55;
			default:      fill_byte = 8'hFF;
		endcase
	endfunction

	task automatic drive_word(input logic [DL_ADDR_W-1:0] addr, input logic [DL_DATA_W-1:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		tick();
		dl_wr   = 1'b0;
	endtask

	// ======================================================================
	// SD host model
	// ======================================================================

	task automatic wait_sd_request(input logic want_rd, input int unsigned lba);
		int unsigned n;
		n = 0;
		while (!(sd_rd || sd_wr)) begin
			assert (n < 2000) else fail_run("Timeout waiting for an SD sector request");
			tick();
			n++;
		end
		check_value("sd_rd", sd_rd, want_rd);
		check_value("sd_wr", sd_wr, !want_rd);
		check_value("sd_lba", sd_lba, lba);
		check_value("bk_busy", bk_busy, 1'b1);
		// Only a load keeps the system off the RAM
		check_value("sys_busy", sys_busy, want_rd);
	endtask

	task automatic load_sector(input int unsigned lba);
		int unsigned a;
		logic [7:0]  b;
		wait_sd_request(1'b1, lba);
		sd_ack = 1'b1;
		tick();
		for (a = 0; a < SECTOR_BYTES; a++) begin
			b = 8'($urandom);
			sd_buff_addr = SECTOR_BITS'(a);
			sd_buff_dout = b;
			sd_buff_wr   = 1'b1;
			model_mem[ADDR_BITS'(lba * SECTOR_BYTES + a)] = b;
			tick();
		end
		sd_buff_wr = 1'b0;
		sd_ack     = 1'b0;
		tick();
	endtask

	// Read data for an address shows up one cycle after it is driven
	task automatic save_sector(input int unsigned lba);
		int unsigned a;
		wait_sd_request(1'b0, lba);
		sd_ack       = 1'b1;
		sd_buff_addr = '0;
		tick();
		for (a = 0; a < SECTOR_BYTES; a++) begin
			check_value("sd_buff_din", sd_buff_din, model_mem[ADDR_BITS'(lba * SECTOR_BYTES + a)]);
			sd_buff_addr = SECTOR_BITS'(a + 1);
			tick();
		end
		sd_ack = 1'b0;
		tick();
	endtask

	task automatic run_transfer(input logic load);
		int unsigned lba;
		int unsigned n;
		for (lba = 0; lba <= (ram_mask_m >> SECTOR_BITS); lba++) begin
			if (load)
				load_sector(lba);
			else
				save_sector(lba);
		end
		n = 0;
		while (bk_busy) begin
			assert (n < 100) else fail_run("Timeout waiting for the backup transfer to finish");
			tick();
			n++;
		end
		check_value("sd_rd", sd_rd, 1'b0);
		check_value("sd_wr", sd_wr, 1'b0);
	endtask

	task automatic request_transfer(input logic load);
		bk_load_req = load;
		bk_save_req = !load;
		tick();
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		run_transfer(load);
	endtask

	task automatic check_blocked();
		int unsigned n;
		bk_load_req = 1'b1;
		tick();
		bk_load_req = 1'b0;
		bk_save_req = 1'b1;
		tick();
		bk_save_req = 1'b0;
		for (n = 0; n < 200; n++) begin
			assert (!sd_rd && !sd_wr) else fail_run("SD request issued while backup is disabled");
			tick();
		end
		check_value("bk_busy", bk_busy, 1'b0);
	endtask

	// ======================================================================
	// System port and download
	// ======================================================================

	task automatic sys_write(input logic [MASK_W-1:0] addr, input logic [7:0] data);
		assert (!sys_busy) else fail_run("System write attempted while sys_busy is high");
		sys_addr  = addr;
		sys_wdata = data;
		sys_wr    = 1'b1;
		tick();
		sys_wr    = 1'b0;
		model_mem[ADDR_BITS'(addr & ram_mask_m)] = data;
	endtask

	task automatic sys_read_check(input logic [MASK_W-1:0] addr);
		assert (!sys_busy) else fail_run("System read attempted while sys_busy is high");
		sys_addr = addr;
		sys_rd   = 1'b1;
		tick();
		sys_rd   = 1'b0;
		check_value("sys_rdata", sys_rdata, model_mem[ADDR_BITS'(addr & ram_mask_m)]);
	endtask

	task automatic run_download(input logic mount, input logic ro);
		logic [7:0]           size_byte;
		logic [7:0]           type_byte;
		logic [15:0]          region_word;
		logic [3:0]           hdr_rom;
		logic [3:0]           hdr_ram;
		logic [DL_ADDR_W-1:0] base;
		logic [3:0]           rom_sz;
		logic [3:0]           ram_sz;
		logic [7:0]           type_exp;
		logic [MASK_W-1:0]    rom_mask_exp;
		int unsigned          n;

		size_byte   = {4'(1 + $urandom % 2), 4'($urandom % 13)};
		type_byte   = 8'($urandom);
		region_word = 16'($urandom);
		hdr_rom     = 4'($urandom % 13);
		hdr_ram     = 4'(1 + $urandom % 2);
		case (map_sel)
			map_lorom:   base = HDR_LOROM;
			map_hirom:   base = HDR_HIROM;
			map_exhirom: base = HDR_EXHIROM;
			default:     base = ($urandom % 2) ? HDR_HIROM : HDR_LOROM;
		endcase

		// Header rules for the chosen map
		rom_sz   = 4'hC;
		ram_sz   = 4'h0;
		type_exp = (map_sel == map_hirom) ? 8'd1 : (map_sel == map_exhirom) ? 8'd2 : 8'd0;
		if (map_sel == map_auto) begin
			rom_sz   = size_byte[3:0];
			ram_sz   = size_byte[7:4];
			type_exp = type_byte;
		end else if (map_sel != map_no_header) begin
			rom_sz = hdr_rom;
			ram_sz = hdr_ram;
		end
		rom_mask_exp = MASK_W'((32'd1 << (rom_sz + 10)) - 1);
		ram_mask_m   = (ram_sz == 0) ? '0 : MASK_W'((32'd1 << (ram_sz + 10)) - 1);
		bk_ena_m     = mount && !ro && (ram_mask_m != 0);
		for (n = 0; n < DEPTH; n++)
			model_mem[n] = fill_byte(fill_sel, ADDR_BITS'(n));

		dl_active = 1'b1;
		drive_word('0, {type_byte, size_byte});
		drive_word(DL_ADDR_W'(2), region_word);
		drive_word(base + DL_ADDR_W'(HDR_OFFSET), {4'($urandom), hdr_rom, 8'($urandom)});
		drive_word(base + DL_ADDR_W'(HDR_OFFSET + 2), {12'($urandom), hdr_ram});
		if (mount) begin
			img_readonly = ro;
			img_mounted  = 1'b1;
			tick();
			img_mounted  = 1'b0;
		end
		// Download lasts longer than the RAM clear
		repeat (CLEAR_CYCLES + 16) tick();
		dl_active = 1'b0;
		tick();
		if (bk_ena_m)
			run_transfer(1'b1);
		n = 0;
		while (sys_busy) begin
			assert (n < 100) else fail_run("Timeout waiting for sys_busy to fall after a download");
			tick();
			n++;
		end
		check_value("rom_mask", rom_mask, rom_mask_exp);
		check_value("ram_mask", ram_mask, ram_mask_m);
		check_value("rom_type", rom_type, type_exp);
		check_value("pal", pal,
			(region_sel == region_auto) ? region_word[8] : (region_sel == region_pal));
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		int unsigned iter;
		int unsigned k;
		void'($urandom(32'h28fd));
		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		map_sel      = map_auto;
		region_sel   = region_auto;
		fill_sel     = pat_alt_9966;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sys_addr     = '0;
		sys_wdata    = '0;
		sys_rd       = 1'b0;
		sys_wr       = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		tick();

		// Modes cycle through no mount, writable mount and read-only mount
		for (iter = 0; iter < 9; iter++) begin
			map_sel    = rom_map_e'(3'($urandom % 5));
			region_sel = region_sel_e'(2'($urandom % 3));
			fill_sel   = fill_pat_e'(2'($urandom % 4));
			// One writable mount without any save RAM
			if (iter == 4)
				map_sel = map_no_header;
			run_download(iter % 3 != 0, iter % 3 == 2);
			for (k = 0; k < 32; k++)
				sys_read_check(MASK_W'($urandom));
			for (k = 0; k < 32; k++)
				sys_write(MASK_W'($urandom), 8'($urandom));
			for (k = 0; k < 32; k++)
				sys_read_check(MASK_W'($urandom));
			if (bk_ena_m) begin
				request_transfer(1'b0);
				request_transfer(1'b1);
				for (k = 0; k < 64; k++)
					sys_read_check(MASK_W'($urandom));
			end else begin
				check_blocked();
			end
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: cart_top.sv
// Top of the cartridge load and backup RAM subsystem, instantiated by the testbench as the DUT
`default_nettype none
`timescale 1ns/1ps

module cart_top
	import snes_cart_pkg::*;
#(
	parameter int SAVE_ADDR_BITS = 12
) (
	input  wire                    clk_sys,
	input  wire                    RESET,

	// Cartridge download stream
	input  wire                    dl_active,
	input  wire [DL_ADDR_W-1:0]    dl_addr,
	input  wire [DL_DATA_W-1:0]    dl_data,
	input  wire                    dl_wr,

	input  wire rom_map_e          map_sel,
	input  wire region_sel_e       region_sel,
	input  wire fill_pat_e         fill_sel,

	// SD image and sector buffer
	input  wire                    img_mounted,
	input  wire                    img_readonly,
	input  wire                    bk_load_req,
	input  wire                    bk_save_req,
	output logic [LBA_W-1:0]       sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	input  wire                    sd_ack,
	input  wire [SECTOR_BITS-1:0]  sd_buff_addr,
	input  wire [7:0]              sd_buff_dout,
	input  wire                    sd_buff_wr,
	output logic [7:0]             sd_buff_din,

	// Emulated cartridge access
	input  wire [MASK_W-1:0]       sys_addr,
	input  wire [7:0]              sys_wdata,
	input  wire                    sys_rd,
	input  wire                    sys_wr,
	output logic [7:0]             sys_rdata,

	output logic [MASK_W-1:0]      rom_mask,
	output logic [MASK_W-1:0]      ram_mask,
	output logic [7:0]             rom_type,
	output logic                   pal,
	output logic                   sys_busy,
	output logic                   bk_busy
);

	logic                      clearing;
	logic                      clr_we;
	logic [SAVE_ADDR_BITS-1:0] clr_addr;
	logic [7:0]                clr_data;
	logic                      bk_loading;
	logic [SAVE_ADDR_BITS-1:0] ram_addr;
	logic [7:0]                ram_wdata;
	logic                      ram_we;
	logic [7:0]                ram_q;

	header_detect u_header_detect (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active(dl_active), .dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr),
		.map_sel(map_sel), .region_sel(region_sel),
		.rom_type(rom_type), .ram_size(),
		.rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	ram_clear #(.SAVE_ADDR_BITS(SAVE_ADDR_BITS)) u_ram_clear (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active(dl_active), .fill_sel(fill_sel),
		.clearing(clearing), .clr_we(clr_we), .clr_addr(clr_addr), .clr_data(clr_data)
	);

	backup_sync #(.SAVE_ADDR_BITS(SAVE_ADDR_BITS)) u_backup_sync (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active(dl_active), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.ram_mask(ram_mask), .bk_load_req(bk_load_req), .bk_save_req(bk_save_req),
		.sd_ack(sd_ack), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_busy(bk_busy), .bk_loading(bk_loading)
	);

	mem_arbiter #(.SAVE_ADDR_BITS(SAVE_ADDR_BITS)) u_mem_arbiter (
		.clk_sys(clk_sys),
		.clearing(clearing), .clr_we(clr_we), .clr_addr(clr_addr), .clr_data(clr_data),
		.sd_ack(sd_ack), .sd_lba(sd_lba), .sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr),
		.sys_addr(sys_addr), .sys_wdata(sys_wdata), .sys_rd(sys_rd), .sys_wr(sys_wr),
		.ram_mask(ram_mask), .ram_q(ram_q),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
		.sd_buff_din(sd_buff_din), .sys_rdata(sys_rdata)
	);

	save_ram #(.SAVE_ADDR_BITS(SAVE_ADDR_BITS)) u_save_ram (
		.clk_sys(clk_sys),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we), .ram_q(ram_q)
	);

	// System must keep off the RAM while any of these run
	assign sys_busy = dl_active | clearing | bk_loading;

endmodule

`default_nettype wire

// File: save_ram.sv
// Byte-wide single-port save RAM, read data one cycle after the address
`default_nettype none
`timescale 1ns/1ps

module save_ram #(
	parameter int SAVE_ADDR_BITS = 12
) (
	input  wire                       clk_sys,
	input  wire [SAVE_ADDR_BITS-1:0]  ram_addr,
	input  wire [7:0]                 ram_wdata,
	input  wire                       ram_we,
	output logic [7:0]                ram_q
);

	localparam int DEPTH = 1 << SAVE_ADDR_BITS;

	logic [7:0] mem [0:DEPTH-1];

	// Read returns the old byte on a write cycle
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		ram_q <= mem[ram_addr];
	end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
// Shares the save RAM between the clear engine, the SD buffer and the system port
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter
	import snes_cart_pkg::*;
#(
	parameter int SAVE_ADDR_BITS = 12
) (
	input  wire                       clk_sys,
	input  wire                       clearing,
	input  wire                       clr_we,
	input  wire [SAVE_ADDR_BITS-1:0]  clr_addr,
	input  wire [7:0]                 clr_data,
	input  wire                       sd_ack,
	input  wire [LBA_W-1:0]           sd_lba,
	input  wire [SECTOR_BITS-1:0]     sd_buff_addr,
	input  wire [7:0]                 sd_buff_dout,
	input  wire                       sd_buff_wr,
	input  wire [MASK_W-1:0]          sys_addr,
	input  wire [7:0]                 sys_wdata,
	input  wire                       sys_rd,
	input  wire                       sys_wr,
	input  wire [MASK_W-1:0]          ram_mask,
	input  wire [7:0]                 ram_q,
	output logic [SAVE_ADDR_BITS-1:0] ram_addr,
	output logic [7:0]                ram_wdata,
	output logic                      ram_we,
	output logic [7:0]                sd_buff_din,
	output logic [7:0]                sys_rdata
);

	localparam int LBA_BITS = SAVE_ADDR_BITS - SECTOR_BITS;

	logic              grant_clr;
	logic              grant_sd;
	logic              grant_sys;
	logic              sd_rd_q;
	logic              sys_rd_q;
	logic [MASK_W-1:0] sys_addr_m;

	// Fixed priority where losers are simply dropped
	assign grant_clr  = clearing;
	assign grant_sd   = ~clearing & sd_ack;
	assign grant_sys  = ~clearing & ~sd_ack & (sys_rd | sys_wr);
	assign sys_addr_m = sys_addr & ram_mask;

	always_comb begin
		ram_addr  = sys_addr_m[SAVE_ADDR_BITS-1:0];
		ram_wdata = sys_wdata;
		ram_we    = grant_sys & sys_wr;
		if (grant_clr) begin
			ram_addr  = clr_addr;
			ram_wdata = clr_data;
			ram_we    = clr_we;
		end else if (grant_sd) begin
			// Byte address within the sector window of the current LBA
			ram_addr  = {sd_lba[LBA_BITS-1:0], sd_buff_addr};
			ram_wdata = sd_buff_dout;
			ram_we    = sd_buff_wr;
		end
	end

	// Read data owner for the cycle after the access
	always_ff @(posedge clk_sys) begin
		sd_rd_q  <= grant_sd & ~sd_buff_wr;
		sys_rd_q <= grant_sys & sys_rd & ~sys_wr;
	end

	assign sd_buff_din = sd_rd_q  ? ram_q : 8'h00;
	assign sys_rdata   = sys_rd_q ? ram_q : 8'h00;

	// System port stays off the RAM during a clear
	a_sys_not_clearing: assert property (@(posedge clk_sys)
		(sys_rd || sys_wr) |-> !clearing);

endmodule

`default_nettype wire

// File: backup_sync.sv
// Moves the save RAM to and from the SD card sector by sector on load, save or mount
`default_nettype none
`timescale 1ns/1ps

module backup_sync
	import snes_cart_pkg::*;
#(
	parameter int SAVE_ADDR_BITS = 12
) (
	input  wire                 clk_sys,
	input  wire                 RESET,
	input  wire                 dl_active,
	input  wire                 img_mounted,
	input  wire                 img_readonly,
	input  wire [MASK_W-1:0]    ram_mask,
	input  wire                 bk_load_req,
	input  wire                 bk_save_req,
	input  wire                 sd_ack,
	output logic [LBA_W-1:0]    sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic                bk_busy,
	output logic                bk_loading
);

	localparam int LBA_BITS = SAVE_ADDR_BITS - SECTOR_BITS;

	bk_state_e         bk_state;
	logic              bk_ena;
	logic              dl_active_d;
	logic              load_req_d;
	logic              save_req_d;
	logic              sd_ack_d;
	logic [LBA_W-1:0]  lba_last;

	wire dl_rise   = dl_active & ~dl_active_d;
	wire dl_fall   = ~dl_active & dl_active_d;
	wire load_rise = bk_load_req & ~load_req_d & bk_ena;
	wire save_rise = bk_save_req & ~save_req_d & bk_ena;
	wire ack_rise  = sd_ack & ~sd_ack_d;
	wire ack_fall  = ~sd_ack & sd_ack_d;

	// Last sector of the cartridge RAM capped at the physical RAM size
	always_comb begin
		if (ram_mask[MASK_W-1:SAVE_ADDR_BITS] != '0)
			lba_last = LBA_W'((1 << LBA_BITS) - 1);
		else
			lba_last = LBA_W'(ram_mask[SAVE_ADDR_BITS-1:SECTOR_BITS]);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_state    <= bk_idle;
			bk_ena      <= 1'b0;
			bk_loading  <= 1'b0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			sd_lba      <= '0;
			dl_active_d <= 1'b0;
			load_req_d  <= 1'b0;
			save_req_d  <= 1'b0;
			sd_ack_d    <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			load_req_d  <= bk_load_req;
			save_req_d  <= bk_save_req;
			sd_ack_d    <= sd_ack;

			// Save file gets mounted near the end of the download
			if (dl_rise)
				bk_ena <= 1'b0;
			if (dl_active && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			case (bk_state)
				bk_idle: begin
					if (load_rise || save_rise) begin
						bk_state   <= bk_request;
						bk_loading <= load_rise;
						sd_lba     <= '0;
						sd_rd      <= load_rise;
						sd_wr      <= ~load_rise;
					end
					// Restore the save file right after the ROM is in
					if (dl_fall && bk_ena) begin
						bk_state   <= bk_request;
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end
				end
				bk_request: begin
					if (ack_rise) begin
						sd_rd    <= 1'b0;
						sd_wr    <= 1'b0;
						bk_state <= bk_transfer;
					end
				end
				bk_transfer: begin
					if (ack_fall) begin
						if (sd_lba >= lba_last) begin
							bk_state   <= bk_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba   <= sd_lba + 1'b1;
							sd_rd    <= bk_loading;
							sd_wr    <= ~bk_loading;
							bk_state <= bk_request;
						end
					end
				end
				default: bk_state <= bk_idle;
			endcase
		end
	end

	assign bk_busy = (bk_state != bk_idle);

	// Exactly one request line in the request state and none elsewhere
	a_one_request: assert property (@(posedge clk_sys) disable iff (RESET)
		(bk_state == bk_request) ? (sd_rd != sd_wr) : !(sd_rd || sd_wr));

endmodule

`default_nettype wire

// File: ram_clear.sv
// Fills every save RAM address with the selected pattern when a download starts
`default_nettype none
`timescale 1ns/1ps

module ram_clear
	import snes_cart_pkg::*;
#(
	parameter int SAVE_ADDR_BITS = 12
) (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire                       dl_active,
	input  wire fill_pat_e            fill_sel,
	output logic                      clearing,
	output logic                      clr_we,
	output logic [SAVE_ADDR_BITS-1:0] clr_addr,
	output logic [7:0]                clr_data
);

	logic dl_active_d;
	logic fill_wait;

	// One write, one idle cycle per address
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_d <= 1'b0;
			clearing    <= 1'b0;
			fill_wait   <= 1'b0;
			clr_addr    <= '0;
		end else begin
			dl_active_d <= dl_active;
			if (clearing) begin
				fill_wait <= ~fill_wait;
				if (fill_wait) begin
					clr_addr <= clr_addr + 1'b1;
					if (&clr_addr)
						clearing <= 1'b0;
				end
			end else begin
				clr_addr  <= '0;
				fill_wait <= 1'b0;
			end
			if (dl_active && !dl_active_d)
				clearing <= 1'b1;
		end
	end

	assign clr_we = clearing & ~fill_wait;

	// Power-on patterns seen on real consoles
	always_comb begin
		case (fill_sel)
			pat_alt_9966: clr_data = (clr_addr[8] ^ clr_addr[2]) ? 8'h66 : 8'h99;
			pat_alt_00ff: clr_data = (clr_addr[9] ^ clr_addr[0]) ? 8'hFF : 8'h00;
			pat_const_55: clr_data = 8'h55;
			default:      clr_data = 8'hFF;
		endcase
	end

	// Writes step through the addresses in ascending order
	a_clear_ascending: assert property (@(posedge clk_sys) disable iff (RESET)
		(clr_we && clr_addr != '0) |-> clr_addr == $past(clr_addr, 2) + 1'b1);

endmodule

`default_nettype wire

// File: header_detect.sv
// Watches the cartridge download and derives ROM/RAM sizes, map type, region and address masks
`default_nettype none
`timescale 1ns/1ps

module header_detect
	import snes_cart_pkg::*;
(
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     dl_active,
	input  wire [DL_ADDR_W-1:0]     dl_addr,
	input  wire [DL_DATA_W-1:0]     dl_data,
	input  wire                     dl_wr,
	input  wire rom_map_e           map_sel,
	input  wire region_sel_e        region_sel,
	output logic [7:0]              rom_type,
	output logic [3:0]              ram_size,
	output logic [MASK_W-1:0]       rom_mask,
	output logic [MASK_W-1:0]       ram_mask,
	output logic                    pal
);

	logic [3:0]            rom_size;
	logic                  rom_region;
	logic                  hdr_hit;
	logic [DL_ADDR_W-1:0]  hdr_base;
	logic [DL_ADDR_W-1:0]  rom_size_addr;
	logic [DL_ADDR_W-1:0]  ram_size_addr;

	// Header location for a forced map
	always_comb begin
		hdr_hit  = 1'b1;
		hdr_base = HDR_LOROM;
		case (map_sel)
			map_lorom:   hdr_base = HDR_LOROM;
			map_hirom:   hdr_base = HDR_HIROM;
			map_exhirom: hdr_base = HDR_EXHIROM;
			default:     hdr_hit  = 1'b0;
		endcase
		rom_size_addr = hdr_base + DL_ADDR_W'(HDR_OFFSET);
		ram_size_addr = hdr_base + DL_ADDR_W'(HDR_OFFSET + 2);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'h0;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (dl_active) begin
			if (dl_wr) begin
				// First word carries the loader's own size and type bytes
				if (dl_addr == '0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					if (map_sel == map_auto && dl_data[7:0] != 8'h00)
						{ram_size, rom_size} <= dl_data[7:0];
					case (map_sel)
						map_no_header: rom_type <= 8'd0;
						map_lorom:     rom_type <= 8'd0;
						map_hirom:     rom_type <= 8'd1;
						map_exhirom:   rom_type <= 8'd2;
						default:       rom_type <= dl_data[15:8];
					endcase
				end

				if (dl_addr == DL_ADDR_W'(2))
					rom_region <= dl_data[8];

				// Forced map reads sizes from the cartridge's internal header
				if (hdr_hit && dl_addr == rom_size_addr)
					rom_size <= dl_data[11:8];
				if (hdr_hit && dl_addr == ram_size_addr)
					ram_size <= dl_data[3:0];
			end
		end else begin
			pal <= (region_sel == region_auto) ? rom_region : (region_sel == region_pal);
		end
	end

	// Masks in bytes, 1 KB times a power of two
	assign rom_mask = (MASK_W'(1024) << rom_size) - 1'b1;
	assign ram_mask = (ram_size != 4'h0) ? (MASK_W'(1024) << ram_size) - 1'b1 : '0;

endmodule

`default_nettype wire

// File: snes_cart_pkg.sv
// Types and constants shared by the cartridge load and save RAM modules, imported by wildcard
`default_nettype none

package snes_cart_pkg;

	// ======================================================================
	// User settings
	// ======================================================================

	// ROM header mapping choice
	typedef enum logic [2:0] {
		map_auto      = 3'd0,
		map_no_header = 3'd1,
		map_lorom     = 3'd2,
		map_hirom     = 3'd3,
		map_exhirom   = 3'd4
	} rom_map_e;

	typedef enum logic [1:0] {
		region_auto = 2'd0,
		region_ntsc = 2'd1,
		region_pal  = 2'd2
	} region_sel_e;

	// Initial contents written over the save RAM
	typedef enum logic [1:0] {
		pat_alt_9966 = 2'd0,
		pat_alt_00ff = 2'd1,
		pat_const_55 = 2'd2,
		pat_const_ff = 2'd3
	} fill_pat_e;

	// Backup RAM sector sequencer
	typedef enum logic [1:0] {
		bk_idle     = 2'd0,
		bk_request  = 2'd1,
		bk_transfer = 2'd2
	} bk_state_e;

	// ======================================================================
	// Widths and header layout
	// ======================================================================

	localparam int MASK_W       = 24;
	localparam int DL_ADDR_W    = 25;
	localparam int DL_DATA_W    = 16;
	localparam int SECTOR_BYTES = 512;
	localparam int SECTOR_BITS  = $clog2(SECTOR_BYTES);
	localparam int LBA_W        = 32;

	// Copier header in front of the ROM image
	localparam int HDR_OFFSET = 512;

	// Internal header bases, size bytes at base and base + 2
	localparam logic [DL_ADDR_W-1:0] HDR_LOROM   = 25'h000_7FD6;
	localparam logic [DL_ADDR_W-1:0] HDR_HIROM   = 25'h000_FFD6;
	localparam logic [DL_ADDR_W-1:0] HDR_EXHIROM = 25'h040_FFD6;

endpackage

`default_nettype wire
